//--- Makefile
VERILATOR  := verilator
TOP        := rom_subsystem_tb
FLIST      := flist.f
FLAGS      := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Regression failed
PASS_MSG   := Regression passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
hdl/rom_sub_pkg.sv
hdl/ar_decoder.sv
hdl/rom_array.sv
hdl/rom_bank_slave.sv
hdl/r_arbiter.sv
hdl/rom_subsystem.sv
tests/rom_subsystem_sva.sv
tests/rom_subsystem_tb.sv

//--- hdl/ar_decoder.sv
`timescale 1ns/1ps

module ar_decoder #(
  parameter int NUM_BANKS = 4
) (
  input  logic                 ar_valid,
  output logic                 ar_ready,
  input  rom_sub_pkg::ar_req_t ar_req,
  output logic [NUM_BANKS-1:0] bank_ar_valid,
  output rom_sub_pkg::ar_req_t bank_ar_req [NUM_BANKS],
  input  logic [NUM_BANKS-1:0] bank_ar_ready
);

  localparam int SEL_W = $clog2(NUM_BANKS);

  logic [SEL_W-1:0] bank_sel;

  // Top bits of the word address pick the bank.
  assign bank_sel = ar_req.addr[15 -: SEL_W];

  // Request payload goes to every bank, only valid is steered.
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_ar_req[i] = ar_req;
    end
  end

  always_comb begin
    bank_ar_valid           = '0;
    bank_ar_valid[bank_sel] = ar_valid;
  end

  assign ar_ready = bank_ar_ready[bank_sel];

endmodule

//--- hdl/r_arbiter.sv
`timescale 1ns/1ps

module r_arbiter #(
  parameter int NUM_BANKS = 4
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic [NUM_BANKS-1:0] bank_r_valid,
  input  rom_sub_pkg::r_beat_t bank_r_beat [NUM_BANKS],
  output logic [NUM_BANKS-1:0] bank_r_ready,
  output logic                 r_valid,
  input  logic                 r_ready,
  output rom_sub_pkg::r_beat_t r_beat
);

  localparam int SEL_W = $clog2(NUM_BANKS);

  logic             locked;
  logic [SEL_W-1:0] grant_q;
  logic [SEL_W-1:0] pick;
  logic [SEL_W-1:0] sel;

  // Round robin search, starting after the previous winner.
  always_comb begin
    logic [SEL_W-1:0] idx;
    logic             found;
    pick  = grant_q;
    found = 1'b0;
    for (int i = 1; i <= NUM_BANKS; i++) begin
      idx = grant_q + SEL_W'(i);
      if (!found && bank_r_valid[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
  end

  assign sel = locked ? grant_q : pick;

  assign r_valid = bank_r_valid[sel];
  assign r_beat  = bank_r_beat[sel];

  always_comb begin
    bank_r_ready      = '0;
    bank_r_ready[sel] = r_ready;
  end

  // Lock as soon as a beat is offered, so a stalled beat keeps its source.
  // Released by the transfer carrying last.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      locked  <= 1'b0;
      grant_q <= '0;
    end else if (r_valid) begin
      locked  <= !(r_ready && r_beat.last);
      grant_q <= sel;
    end
  end

endmodule

//--- hdl/rom_array.sv
`timescale 1ns/1ps

module rom_array (
  input  logic                    clk,
  input  logic                    rom_enable,
  input  logic                    rom_read,
  input  rom_sub_pkg::word_addr_t rom_address,
  output rom_sub_pkg::rom_data_t  rom_out
);

  logic rd_strobe;

  // Chip enable and read strobe together start an access.
  assign rd_strobe = rom_enable & rom_read;

  // Registered output, held when no access.
  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      rom_out <= rom_sub_pkg::rom_word(rom_address);
    end
  end

endmodule

//--- hdl/rom_bank_slave.sv
`timescale 1ns/1ps

module rom_bank_slave (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  rom_sub_pkg::ar_req_t    ar_req,
  output logic                    r_valid,
  input  logic                    r_ready,
  output rom_sub_pkg::r_beat_t    r_beat,
  input  rom_sub_pkg::rom_data_t  rom_out,
  output logic                    rom_enable,
  output logic                    rom_read,
  output rom_sub_pkg::word_addr_t rom_address
);

  rom_sub_pkg::bank_state_t state, state_next;

  rom_sub_pkg::axi_id_t    id_q;
  rom_sub_pkg::word_addr_t base_q;
  rom_sub_pkg::axi_len_t   len_q;
  rom_sub_pkg::axi_len_t   beat_cnt;
  rom_sub_pkg::word_addr_t cur_addr;

  logic ar_fire;
  logic r_fire;
  logic last_beat;

  assign ar_fire   = ar_valid & ar_ready;
  assign r_fire    = r_valid & r_ready;
  assign last_beat = (beat_cnt == len_q);
  assign cur_addr  = base_q + rom_sub_pkg::word_addr_t'(beat_cnt);

  // Next burst may start in the cycle the final beat leaves.
  assign ar_ready = (state == rom_sub_pkg::IDLE) | (r_fire & last_beat);
  assign r_valid  = (state == rom_sub_pkg::READ);

  assign r_beat.id   = id_q;
  assign r_beat.data = rom_out;
  assign r_beat.resp = rom_sub_pkg::RESP_OKAY;
  assign r_beat.last = last_beat;

  always_comb begin
    state_next = state;
    if (ar_fire) begin
      state_next = rom_sub_pkg::READ;
    end else if (r_fire && last_beat) begin
      state_next = rom_sub_pkg::IDLE;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= rom_sub_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt <= '0;
    end else if (ar_fire) begin
      beat_cnt <= '0;
    end else if (r_fire) begin
      beat_cnt <= beat_cnt + 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q   <= ar_req.id;
      base_q <= ar_req.addr[15:2];
      len_q  <= ar_req.len;
    end
  end

  // ROM read control.
  // During a stall the current word is read again, so data holds.
  always_comb begin
    rom_enable  = 1'b0;
    rom_read    = 1'b0;
    rom_address = cur_addr;
    if (ar_fire) begin
      rom_enable  = 1'b1;
      rom_read    = 1'b1;
      rom_address = ar_req.addr[15:2];
    end else if (state == rom_sub_pkg::READ && !(r_fire && last_beat)) begin
      rom_enable  = 1'b1;
      rom_read    = 1'b1;
      rom_address = r_fire ? cur_addr + 14'd1 : cur_addr;
    end
  end

endmodule

//--- hdl/rom_sub_pkg.sv
package rom_sub_pkg;

  // Widths seen on the read address and read data channels.
  typedef logic [3:0]  axi_id_t;
  typedef logic [15:0] axi_addr_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [1:0]  axi_resp_t;

  // ROM side.
  typedef logic [31:0] rom_data_t;
  typedef logic [13:0] word_addr_t;

  // Read address request.
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } ar_req_t;

  // One read data beat.
  typedef struct packed {
    axi_id_t   id;
    rom_data_t data;
    axi_resp_t resp;
    logic      last;
  } r_beat_t;

  typedef enum logic {
    IDLE,
    READ
  } bank_state_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // Fixed pattern mixed into every ROM word.
  localparam rom_data_t ROM_PATTERN = 32'hA5C3_0000;

  // Content of the ROM at a given word address.
  function automatic rom_data_t rom_word(input word_addr_t waddr);
    rom_data_t word;
    word = {18'd0, waddr};
    return word ^ ROM_PATTERN;
  endfunction

endpackage

//--- hdl/rom_subsystem.sv
`timescale 1ns/1ps

module rom_subsystem #(
  parameter int NUM_BANKS = 4
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 ar_valid,
  output logic                 ar_ready,
  input  rom_sub_pkg::ar_req_t ar_req,
  output logic                 r_valid,
  input  logic                 r_ready,
  output rom_sub_pkg::r_beat_t r_beat
);

  logic [NUM_BANKS-1:0] bank_ar_valid;
  logic [NUM_BANKS-1:0] bank_ar_ready;
  rom_sub_pkg::ar_req_t bank_ar_req [NUM_BANKS];

  logic [NUM_BANKS-1:0] bank_r_valid;
  logic [NUM_BANKS-1:0] bank_r_ready;
  rom_sub_pkg::r_beat_t bank_r_beat [NUM_BANKS];

  logic [NUM_BANKS-1:0]    rom_enable;
  logic [NUM_BANKS-1:0]    rom_read;
  rom_sub_pkg::word_addr_t rom_address [NUM_BANKS];
  rom_sub_pkg::rom_data_t  rom_out [NUM_BANKS];

  ar_decoder #(
    .NUM_BANKS(NUM_BANKS)
  ) ar_decoder_i (
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar_req       (ar_req),
    .bank_ar_valid(bank_ar_valid),
    .bank_ar_req  (bank_ar_req),
    .bank_ar_ready(bank_ar_ready)
  );

  // One burst engine and ROM per bank.
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    rom_bank_slave rom_bank_slave_i (
      .clk        (clk),
      .rstn       (rstn),
      .ar_valid   (bank_ar_valid[i]),
      .ar_ready   (bank_ar_ready[i]),
      .ar_req     (bank_ar_req[i]),
      .r_valid    (bank_r_valid[i]),
      .r_ready    (bank_r_ready[i]),
      .r_beat     (bank_r_beat[i]),
      .rom_out    (rom_out[i]),
      .rom_enable (rom_enable[i]),
      .rom_read   (rom_read[i]),
      .rom_address(rom_address[i])
    );

    rom_array rom_array_i (
      .clk        (clk),
      .rom_enable (rom_enable[i]),
      .rom_read   (rom_read[i]),
      .rom_address(rom_address[i]),
      .rom_out    (rom_out[i])
    );
  end

  r_arbiter #(
    .NUM_BANKS(NUM_BANKS)
  ) r_arbiter_i (
    .clk         (clk),
    .rstn        (rstn),
    .bank_r_valid(bank_r_valid),
    .bank_r_beat (bank_r_beat),
    .bank_r_ready(bank_r_ready),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r_beat      (r_beat)
  );

endmodule

//--- tests/rom_subsystem_sva.sv
`timescale 1ns/1ps

module rom_subsystem_sva (
  input logic                 clk,
  input logic                 rstn,
  input logic                 ar_valid,
  input logic                 ar_ready,
  input rom_sub_pkg::ar_req_t ar_req,
  input logic                 r_valid,
  input logic                 r_ready,
  input rom_sub_pkg::r_beat_t r_beat
);

  // No read data while in reset.
  property r_idle_in_reset;
    @(posedge clk) !rstn |-> !r_valid;
  endproperty

  // A stalled beat is held until it is taken.
  property r_hold_on_stall;
    @(posedge clk) disable iff (!rstn)
      r_valid && !r_ready |=> r_valid && $stable(r_beat);
  endproperty

  // Driver side rule on the AR channel.
  property ar_hold_on_stall;
    @(posedge clk) disable iff (!rstn)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_req);
  endproperty

  r_idle_in_reset_a: assert property (r_idle_in_reset)
    else $error("r_valid high during reset");

  r_hold_on_stall_a: assert property (r_hold_on_stall)
    else $error("r_beat changed or r_valid dropped during a stall");

  ar_hold_on_stall_a: assert property (ar_hold_on_stall)
    else $error("ar_req changed or ar_valid dropped before the AR transfer");

endmodule

bind rom_subsystem rom_subsystem_sva rom_subsystem_sva_i (
  .clk     (clk),
  .rstn    (rstn),
  .ar_valid(ar_valid),
  .ar_ready(ar_ready),
  .ar_req  (ar_req),
  .r_valid (r_valid),
  .r_ready (r_ready),
  .r_beat  (r_beat)
);

//--- tests/rom_subsystem_tb.sv
`timescale 1ns/1ps

module rom_subsystem_tb;

  localparam int NUM_BANKS   = 4;
  localparam int NUM_ENTRIES = 9;

  // One read request, and whether R is throttled once it is issued.
  typedef struct packed {
    rom_sub_pkg::axi_id_t   id;
    rom_sub_pkg::axi_addr_t addr;
    rom_sub_pkg::axi_len_t  len;
    logic                   bp;
  } stim_t;

  logic                 clk;
  logic                 rstn;
  logic                 ar_valid;
  logic                 ar_ready;
  rom_sub_pkg::ar_req_t ar_req;
  logic                 r_valid;
  logic                 r_ready;
  rom_sub_pkg::r_beat_t r_beat;

  stim_t                stim_table [NUM_ENTRIES];
  rom_sub_pkg::r_beat_t exp_q [16][$];

  integer seed;
  integer rnd;
  logic   bp_mode;
  int     total_beats;
  int     beats_seen;
  int     cycle_cnt;
  int     timeout_limit;

  logic                 stalled;
  rom_sub_pkg::r_beat_t held_beat;
  logic                 burst_open;
  rom_sub_pkg::axi_id_t open_id;

  rom_subsystem #(
    .NUM_BANKS(NUM_BANKS)
  ) rom_subsystem_i (
    .clk     (clk),
    .rstn    (rstn),
    .ar_valid(ar_valid),
    .ar_ready(ar_ready),
    .ar_req  (ar_req),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .r_beat  (r_beat)
  );

  always #5 clk = ~clk;

  // Word address in the low bits, XOR a fixed pattern.
  function automatic rom_sub_pkg::rom_data_t expected_word(
    input rom_sub_pkg::word_addr_t waddr
  );
    return {18'd0, waddr} ^ 32'hA5C3_0000;
  endfunction

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic load_table();
    stim_table[0] = '{id: 4'd1, addr: 16'h0010, len: 8'd0,  bp: 1'b0};
    stim_table[1] = '{id: 4'd2, addr: 16'h4100, len: 8'd15, bp: 1'b0};
    stim_table[2] = '{id: 4'd3, addr: 16'h8200, len: 8'd7,  bp: 1'b0};
    stim_table[3] = '{id: 4'd4, addr: 16'hC300, len: 8'd3,  bp: 1'b0};
    // Bank 1 still busy with id 2.
    stim_table[4] = '{id: 4'd5, addr: 16'h4800, len: 8'd2,  bp: 1'b0};
    stim_table[5] = '{id: 4'd6, addr: 16'h0040, len: 8'd15, bp: 1'b1};
    stim_table[6] = '{id: 4'd7, addr: 16'h8404, len: 8'd4,  bp: 1'b1};
    stim_table[7] = '{id: 4'd8, addr: 16'hC010, len: 8'd0,  bp: 1'b1};
    // Bank 0 busy again, now under stalls.
    stim_table[8] = '{id: 4'd9, addr: 16'h0400, len: 8'd3,  bp: 1'b1};
  endtask

  task automatic queue_expected(input stim_t s);
    rom_sub_pkg::r_beat_t    beat;
    rom_sub_pkg::word_addr_t waddr;
    for (int k = 0; k <= int'(s.len); k++) begin
      waddr     = s.addr[15:2] + rom_sub_pkg::word_addr_t'(k);
      beat.id   = s.id;
      beat.data = expected_word(waddr);
      beat.resp = rom_sub_pkg::RESP_OKAY;
      beat.last = (k == int'(s.len));
      exp_q[s.id].push_back(beat);
    end
  endtask

  task automatic issue_request(input stim_t s);
    ar_valid    = 1'b1;
    ar_req.id   = s.id;
    ar_req.addr = s.addr;
    ar_req.len  = s.len;
    bp_mode     = s.bp;
    // Ready seen here means the transfer is on the coming edge.
    do begin
      @(negedge clk);
    end while (!ar_ready);
    queue_expected(s);
    @(posedge clk);
    #1;
  endtask

  task automatic check_cycle();
    rom_sub_pkg::r_beat_t want;
    if (stalled) begin
      assert (r_valid) else begin
        $display("ERROR: r_valid dropped while a beat was stalled");
        stop_run();
      end
      assert (r_beat == held_beat) else begin
        $display("FAIL r_beat: got %h, expected %h", r_beat, held_beat);
        stop_run();
      end
    end
    stalled   = r_valid && !r_ready;
    held_beat = r_beat;
    if (r_valid && r_ready) begin
      assert (exp_q[r_beat.id].size() > 0) else begin
        $display("ERROR: a beat with id %h arrived with no request outstanding", r_beat.id);
        stop_run();
      end
      if (burst_open) begin
        assert (r_beat.id == open_id) else begin
          $display("FAIL r_beat.id: got %h, expected %h", r_beat.id, open_id);
          stop_run();
        end
      end
      want = exp_q[r_beat.id].pop_front();
      assert (r_beat.data == want.data) else begin
        $display("FAIL r_beat.data: got %h, expected %h", r_beat.data, want.data);
        stop_run();
      end
      assert (r_beat.resp == want.resp) else begin
        $display("FAIL r_beat.resp: got %h, expected %h", r_beat.resp, want.resp);
        stop_run();
      end
      assert (r_beat.last == want.last) else begin
        $display("FAIL r_beat.last: got %h, expected %h", r_beat.last, want.last);
        stop_run();
      end
      burst_open = !r_beat.last;
      open_id    = r_beat.id;
      beats_seen++;
    end
  endtask

  // Response checker samples at the falling edge.
  initial begin
    stalled    = 1'b0;
    held_beat  = '0;
    burst_open = 1'b0;
    open_id    = '0;
    beats_seen = 0;
    forever begin
      @(negedge clk);
      if (rstn) begin
        check_cycle();
      end
    end
  end

  initial begin
    seed    = 67948;
    r_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!rstn) begin
        r_ready = 1'b0;
      end else if (bp_mode) begin
        rnd     = $random(seed);
        r_ready = rnd[0];
      end else begin
        r_ready = 1'b1;
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= timeout_limit) begin
        $display("ERROR: the run timed out after %0d cycles", cycle_cnt);
        stop_run();
      end
    end
  end

  initial begin
    clk     = 1'b0;
    rstn    = 1'b0;
    ar_valid = 1'b0;
    ar_req  = '0;
    bp_mode = 1'b0;
    load_table();
    total_beats = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      total_beats += int'(stim_table[i].len) + 1;
    end
    timeout_limit = 4 * total_beats + 20 * NUM_ENTRIES + 100;
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      issue_request(stim_table[i]);
    end
    ar_valid = 1'b0;
    ar_req   = '0;
    wait (beats_seen == total_beats);
    repeat (10) @(posedge clk);
    if (!r_valid) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("ERROR: r_valid still high after the last expected beat");
      stop_run();
    end
  end

endmodule
